//--- design/ss_pkg.sv
package ss_pkg;

  // ----------------------------------------------------------------------
  // sizes
  // ----------------------------------------------------------------------

  // rays in flight, one stack row each
  localparam int NUM_RAYS    = 16;
  localparam int RAY_ID_W    = $clog2(NUM_RAYS);

  // short-stack slots per ray
  localparam int STACK_DEPTH = 4;
  localparam int SLOT_W      = $clog2(STACK_DEPTH);

  localparam int NODE_W      = 16;
  localparam int T_W         = 32;

  // ----------------------------------------------------------------------
  // value types
  // ----------------------------------------------------------------------

  typedef logic [RAY_ID_W-1:0] ray_id_t;
  typedef logic [SLOT_W-1:0]   slot_t;
  typedef logic [NODE_W-1:0]   node_id_t;

  // always non-negative, so bit patterns order like the values
  typedef logic [T_W-1:0]      t_val_t;

  // traversal port opcode
  typedef enum logic [2:0] {
    op_pop       = 3'd0,
    op_push      = 3'd1,
    op_upd_scene = 3'd2,
    op_upd_rest  = 3'd3,
    op_push_rest = 3'd4
  } trav_op_e;

  // one memory request per cycle
  typedef enum logic [2:0] {
    rk_none     = 3'd0,
    rk_stack_wr = 3'd1,
    rk_rest_wr  = 3'd2,
    rk_stack_rd = 3'd3,
    rk_rest_rd  = 3'd4
  } req_kind_e;

endpackage

//--- design/ss_links.sv
`timescale 1ns/1ps

// request link, decode to store
interface ss_req_if;
  import ss_pkg::*;

  req_kind_e kind;
  ray_id_t   ray_id;
  slot_t     slot;
  node_id_t  node;
  // restart node for restart writes and push with restart update
  node_id_t  rest_node;
  t_val_t    t;
  logic      rest_node_wr;
  logic      scene_wr;
  // pop context, already decremented
  t_val_t    t_min;
  slot_t     ss_wptr;
  slot_t     ss_num;

  modport producer (output kind, ray_id, slot, node, rest_node, t, rest_node_wr,
                    scene_wr, t_min, ss_wptr, ss_num);
  modport consumer (input kind, ray_id, slot, node, rest_node, t, rest_node_wr,
                    scene_wr, t_min, ss_wptr, ss_num);
endinterface

// read link, store to resolve
interface ss_rd_if;
  import ss_pkg::*;

  logic     valid;
  logic     from_restart;
  ray_id_t  ray_id;
  t_val_t   t_min;
  slot_t    ss_wptr;
  slot_t    ss_num;
  node_id_t rd_node;
  t_val_t   rd_t;

  modport producer (output valid, from_restart, ray_id, t_min, ss_wptr, ss_num,
                    rd_node, rd_t);
  modport consumer (input valid, from_restart, ray_id, t_min, ss_wptr, ss_num,
                    rd_node, rd_t);
endinterface

//--- design/ss_req_decode.sv
`timescale 1ns/1ps

module ss_req_decode (
  input  logic              clk,
  input  logic              rst,
  input  logic              trav_valid,
  input  ss_pkg::trav_op_e  trav_op,
  input  ss_pkg::ray_id_t   trav_ray_id,
  input  ss_pkg::slot_t     trav_ss_wptr,
  input  ss_pkg::slot_t     trav_ss_num,
  input  ss_pkg::node_id_t  trav_push_node,
  input  ss_pkg::node_id_t  trav_rest_node,
  input  ss_pkg::t_val_t    trav_t_max,
  input  logic              sint_valid,
  input  ss_pkg::ray_id_t   sint_ray_id,
  input  ss_pkg::t_val_t    sint_t_max_scene,
  input  logic              list_valid,
  input  ss_pkg::ray_id_t   list_ray_id,
  input  ss_pkg::slot_t     list_ss_wptr,
  input  ss_pkg::slot_t     list_ss_num,
  input  ss_pkg::t_val_t    list_t_max_leaf,
  ss_req_if.producer        req
);
  import ss_pkg::*;

  req_kind_e kind_d;
  ray_id_t   ray_d;
  slot_t     slot_d;
  node_id_t  rest_node_d;
  t_val_t    t_d;
  t_val_t    t_min_d;
  slot_t     wptr_d;
  slot_t     num_d;
  logic      rest_wr_d;
  logic      scene_wr_d;

  // slot below the write pointer, wrapping
  function automatic slot_t prev_slot(input slot_t s);
    return slot_t'((int'(s) + STACK_DEPTH - 1) % STACK_DEPTH);
  endfunction

  // ----------------------------------------------------------------------
  // port strobes to one request
  // ----------------------------------------------------------------------
  always_comb begin
    kind_d      = rk_none;
    ray_d       = trav_ray_id;
    slot_d      = trav_ss_wptr;
    rest_node_d = trav_rest_node;
    t_d         = trav_t_max;
    t_min_d     = trav_t_max;
    wptr_d      = prev_slot(trav_ss_wptr);
    num_d       = trav_ss_num - 1'b1;
    rest_wr_d   = 1'b0;
    scene_wr_d  = 1'b0;
    if (trav_valid) begin
      case (trav_op)
        op_pop: begin
          kind_d = (trav_ss_num != '0) ? rk_stack_rd : rk_rest_rd;
          slot_d = prev_slot(trav_ss_wptr);
        end
        op_push: kind_d = rk_stack_wr;
        op_upd_scene: begin
          kind_d     = rk_rest_wr;
          scene_wr_d = 1'b1;
        end
        // restart node update also records the current max-scene
        op_upd_rest, op_push_rest: begin
          kind_d     = (trav_op == op_push_rest) ? rk_stack_wr : rk_rest_wr;
          rest_wr_d  = 1'b1;
          scene_wr_d = 1'b1;
        end
        default: kind_d = rk_none;
      endcase
    end else if (sint_valid) begin
      kind_d      = rk_rest_wr;
      ray_d       = sint_ray_id;
      rest_node_d = '0;
      t_d         = sint_t_max_scene;
      rest_wr_d   = 1'b1;
      scene_wr_d  = 1'b1;
    end else if (list_valid) begin
      // leaf miss pop
      kind_d  = (list_ss_num != '0) ? rk_stack_rd : rk_rest_rd;
      ray_d   = list_ray_id;
      slot_d  = prev_slot(list_ss_wptr);
      t_min_d = list_t_max_leaf;
      wptr_d  = prev_slot(list_ss_wptr);
      num_d   = list_ss_num - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req.kind <= rk_none;
    end else begin
      req.kind <= kind_d;
    end
    req.ray_id       <= ray_d;
    req.slot         <= slot_d;
    req.node         <= trav_push_node;
    req.rest_node    <= rest_node_d;
    req.t            <= t_d;
    req.rest_node_wr <= rest_wr_d;
    req.scene_wr     <= scene_wr_d;
    req.t_min        <= t_min_d;
    req.ss_wptr      <= wptr_d;
    req.ss_num       <= num_d;
  end

  // the memories rely on a single request per cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0({trav_valid, sint_valid, list_valid}));

endmodule

//--- design/ss_store.sv
`timescale 1ns/1ps

module ss_store (
  input logic        clk,
  input logic        rst,
  ss_req_if.consumer req,
  ss_rd_if.producer  rd
);
  import ss_pkg::*;

  // ----------------------------------------------------------------------
  // memories
  // ----------------------------------------------------------------------

  // stack element is {node, t_max}
  logic [NODE_W+T_W-1:0] stack_mem [NUM_RAYS][STACK_DEPTH];
  node_id_t              rest_node_mem [NUM_RAYS];
  t_val_t                scene_mem [NUM_RAYS];

  logic is_rd;
  logic rest_fields;

  assign is_rd = (req.kind == rk_stack_rd) || (req.kind == rk_rest_rd);

  // a push can carry the restart update along with it
  assign rest_fields = (req.kind == rk_rest_wr) || (req.kind == rk_stack_wr);

  // field enables pick the restart columns on writes
  always_ff @(posedge clk) begin
    if (req.kind == rk_stack_wr) begin
      stack_mem[req.ray_id][req.slot] <= {req.node, req.t};
    end
    if (rest_fields && req.rest_node_wr) begin
      rest_node_mem[req.ray_id] <= req.rest_node;
    end
    if (rest_fields && req.scene_wr) begin
      scene_mem[req.ray_id] <= req.t;
    end
  end

  // ----------------------------------------------------------------------
  // synchronous read with the pop context riding along
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd.valid <= 1'b0;
    end else begin
      rd.valid <= is_rd;
    end
    rd.from_restart <= (req.kind == rk_rest_rd);
    rd.ray_id       <= req.ray_id;
    rd.t_min        <= req.t_min;
    rd.ss_wptr      <= req.ss_wptr;
    rd.ss_num       <= req.ss_num;
    if (req.kind == rk_rest_rd) begin
      rd.rd_node <= rest_node_mem[req.ray_id];
      rd.rd_t    <= scene_mem[req.ray_id];
    end else begin
      {rd.rd_node, rd.rd_t} <= stack_mem[req.ray_id][req.slot];
    end
  end

  // stack requests must name a known slot of the ray's row
  a_slot_range: assert property (@(posedge clk) disable iff (rst)
    (req.kind inside {rk_stack_wr, rk_stack_rd}) |-> !$isunknown(req.slot));

endmodule

//--- design/ss_resolve.sv
`timescale 1ns/1ps

module ss_resolve (
  input  logic              clk,
  input  logic              rst,
  ss_rd_if.consumer         rd,
  output logic              tarb_valid,
  output logic              tarb_restart,
  output ss_pkg::ray_id_t   tarb_ray_id,
  output ss_pkg::node_id_t  tarb_node,
  output ss_pkg::t_val_t    tarb_t_min,
  output ss_pkg::t_val_t    tarb_t_max,
  output ss_pkg::slot_t     tarb_ss_wptr,
  output ss_pkg::slot_t     tarb_ss_num,
  output logic              shader_valid,
  output ss_pkg::ray_id_t   shader_ray_id
);
  import ss_pkg::*;

  logic restart_hit;

  // unsigned compare is enough for non-negative singles
  assign restart_hit = rd.t_min < rd.rd_t;

  // ----------------------------------------------------------------------
  // arbiter and shader results
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tarb_valid   <= 1'b0;
      shader_valid <= 1'b0;
    end else begin
      tarb_valid   <= rd.valid && (!rd.from_restart || restart_hit);
      shader_valid <= rd.valid && rd.from_restart && !restart_hit;
    end
    tarb_restart  <= rd.from_restart;
    tarb_ray_id   <= rd.ray_id;
    tarb_node     <= rd.rd_node;
    tarb_t_min    <= rd.t_min;
    // t_max_scene on a restart and element t_max otherwise
    tarb_t_max    <= rd.rd_t;
    // restart begins with an empty stack
    tarb_ss_wptr  <= rd.from_restart ? '0 : rd.ss_wptr;
    tarb_ss_num   <= rd.from_restart ? '0 : rd.ss_num;
    shader_ray_id <= rd.ray_id;
  end

  a_no_dual: assert property (@(posedge clk) disable iff (rst)
    !(tarb_valid && shader_valid));

endmodule

//--- design/shortstack_unit.sv
`timescale 1ns/1ps

module shortstack_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              trav_valid,
  input  ss_pkg::trav_op_e  trav_op,
  input  ss_pkg::ray_id_t   trav_ray_id,
  input  ss_pkg::slot_t     trav_ss_wptr,
  input  ss_pkg::slot_t     trav_ss_num,
  input  ss_pkg::node_id_t  trav_push_node,
  input  ss_pkg::node_id_t  trav_rest_node,
  input  ss_pkg::t_val_t    trav_t_max,
  input  logic              sint_valid,
  input  ss_pkg::ray_id_t   sint_ray_id,
  input  ss_pkg::t_val_t    sint_t_max_scene,
  input  logic              list_valid,
  input  ss_pkg::ray_id_t   list_ray_id,
  input  ss_pkg::slot_t     list_ss_wptr,
  input  ss_pkg::slot_t     list_ss_num,
  input  ss_pkg::t_val_t    list_t_max_leaf,
  output logic              tarb_valid,
  output logic              tarb_restart,
  output ss_pkg::ray_id_t   tarb_ray_id,
  output ss_pkg::node_id_t  tarb_node,
  output ss_pkg::t_val_t    tarb_t_min,
  output ss_pkg::t_val_t    tarb_t_max,
  output ss_pkg::slot_t     tarb_ss_wptr,
  output ss_pkg::slot_t     tarb_ss_num,
  output logic              shader_valid,
  output ss_pkg::ray_id_t   shader_ray_id
);

  // ----------------------------------------------------------------------
  // decode -> store -> resolve, one cycle each
  // ----------------------------------------------------------------------
  ss_req_if req_link ();
  ss_rd_if  rd_link ();

  ss_req_decode ss_req_decode_i (
    .clk, .rst,
    .trav_valid, .trav_op, .trav_ray_id, .trav_ss_wptr, .trav_ss_num,
    .trav_push_node, .trav_rest_node, .trav_t_max,
    .sint_valid, .sint_ray_id, .sint_t_max_scene,
    .list_valid, .list_ray_id, .list_ss_wptr, .list_ss_num, .list_t_max_leaf,
    .req (req_link.producer)
  );

  ss_store ss_store_i (
    .clk, .rst,
    .req (req_link.consumer),
    .rd  (rd_link.producer)
  );

  ss_resolve ss_resolve_i (
    .clk, .rst,
    .rd (rd_link.consumer),
    .tarb_valid, .tarb_restart, .tarb_ray_id, .tarb_node,
    .tarb_t_min, .tarb_t_max, .tarb_ss_wptr, .tarb_ss_num,
    .shader_valid, .shader_ray_id
  );

endmodule

//--- tests/shortstack_tb.sv
`timescale 1ns/1ps

module shortstack_tb;
  import ss_pkg::*;

  localparam int N_ROWS       = 17;
  localparam int RESET_CYCLES = 10;
  // source port and expected result of a row
  localparam int P_TRAV = 0, P_SINT = 1, P_LIST = 2;
  localparam int K_NONE = 0, K_TARB = 1, K_REST = 2, K_SHADER = 3;

  logic     clk = 1'b0;
  logic     rst;
  logic     trav_valid, sint_valid, list_valid;
  trav_op_e trav_op;
  ray_id_t  trav_ray_id, sint_ray_id, list_ray_id, tarb_ray_id, shader_ray_id;
  slot_t    trav_ss_wptr, trav_ss_num, list_ss_wptr, list_ss_num, tarb_ss_wptr, tarb_ss_num;
  node_id_t trav_push_node, trav_rest_node, tarb_node;
  t_val_t   trav_t_max, sint_t_max_scene, list_t_max_leaf, tarb_t_min, tarb_t_max;
  logic     tarb_valid, tarb_restart, shader_valid;

  // stimulus table
  string    row_name [N_ROWS];
  int       row_port [N_ROWS];
  trav_op_e row_op [N_ROWS];
  ray_id_t  row_ray [N_ROWS];
  slot_t    row_wptr [N_ROWS];
  slot_t    row_num [N_ROWS];
  node_id_t row_pnode [N_ROWS];
  node_id_t row_rnode [N_ROWS];
  t_val_t   row_t [N_ROWS];
  int       row_kind [N_ROWS];
  int       row_gap [N_ROWS];
  int       row_err [N_ROWS];
  // expected fields where t_min is always the row's t
  node_id_t e_node [N_ROWS];
  t_val_t   e_tmax [N_ROWS];
  slot_t    e_wptr [N_ROWS];
  slot_t    e_num [N_ROWS];
  // reference copy of stack, restart node and scene memories
  node_id_t m_node [NUM_RAYS][STACK_DEPTH];
  t_val_t   m_t [NUM_RAYS][STACK_DEPTH];
  node_id_t m_rest [NUM_RAYS];
  t_val_t   m_scene [NUM_RAYS];

  int exp_row [$];
  int exp_due [$];
  int n_add   = 0;
  int neg_cnt = 0;
  int err_cnt = 0;
  int seed    = 75;

  shortstack_unit shortstack_unit_i (.*);

  always #2 clk = ~clk;

  // non-negative finite singles below 2.0
  function automatic t_val_t rand_t();
    return t_val_t'($random(seed)) & 32'h3fff_ffff;
  endfunction

  task automatic add_row(input string name, input int port, input trav_op_e op,
                         input int ray, input int wptr, input int num,
                         input node_id_t pnode, input node_id_t rnode,
                         input t_val_t t, input int kind, input int gap);
    row_name[n_add]  = name;
    row_port[n_add]  = port;
    row_op[n_add]    = op;
    row_ray[n_add]   = ray_id_t'(ray);
    row_wptr[n_add]  = slot_t'(wptr);
    row_num[n_add]   = slot_t'(num);
    row_pnode[n_add] = pnode;
    row_rnode[n_add] = rnode;
    row_t[n_add]     = t;
    row_kind[n_add]  = kind;
    row_gap[n_add]   = gap;
    row_err[n_add]   = 0;
    n_add++;
  endtask

  task automatic note_fail(input int r, input string what);
    $display("ERROR: %s: %s", row_name[r], what);
    row_err[r]++;
    err_cnt++;
  endtask

  task automatic compare_field(input int r, input string field, input logic [31:0] expv,
                               input logic [31:0] actv);
    assert (actv === expv) else begin
      $display("MISMATCH %s %s expected %h actual %h", row_name[r], field, expv, actv);
      row_err[r]++;
      err_cnt++;
    end
  endtask

  task automatic idle_ports();
    trav_valid <= 1'b0;
    sint_valid <= 1'b0;
    list_valid <= 1'b0;
  endtask

  task automatic drive_row(input int r);
    trav_valid       <= (row_port[r] == P_TRAV);
    sint_valid       <= (row_port[r] == P_SINT);
    list_valid       <= (row_port[r] == P_LIST);
    trav_op          <= row_op[r];
    trav_ray_id      <= row_ray[r];
    trav_ss_wptr     <= row_wptr[r];
    trav_ss_num      <= row_num[r];
    trav_push_node   <= row_pnode[r];
    trav_rest_node   <= row_rnode[r];
    trav_t_max       <= row_t[r];
    sint_ray_id      <= row_ray[r];
    sint_t_max_scene <= row_t[r];
    list_ray_id      <= row_ray[r];
    list_ss_wptr     <= row_wptr[r];
    list_ss_num      <= row_num[r];
    list_t_max_leaf  <= row_t[r];
  endtask

  // ----------------------------------------------------------------------
  // reference model applied in strobe order
  // ----------------------------------------------------------------------
  task automatic model_row(input int r);
    ray_id_t ray;
    slot_t   below;
    int      mk;
    ray       = row_ray[r];
    below     = (row_wptr[r] == 2'd0) ? 2'd3 : row_wptr[r] - 2'd1;
    mk        = K_NONE;
    e_wptr[r] = below;
    e_num[r]  = row_num[r] - 2'd1;
    if (row_port[r] == P_SINT) begin
      m_rest[ray]  = '0;
      m_scene[ray] = row_t[r];
    end else if (row_port[r] == P_TRAV && row_op[r] != op_pop) begin
      if (row_op[r] == op_push || row_op[r] == op_push_rest) begin
        m_node[ray][row_wptr[r]] = row_pnode[r];
        m_t[ray][row_wptr[r]]    = row_t[r];
      end
      if (row_op[r] == op_upd_rest || row_op[r] == op_push_rest) begin
        m_rest[ray] = row_rnode[r];
      end
      // restart updates record max-scene as well
      if (row_op[r] != op_push) begin
        m_scene[ray] = row_t[r];
      end
    end else if (row_num[r] != 2'd0) begin
      mk        = K_TARB;
      e_node[r] = m_node[ray][below];
      e_tmax[r] = m_t[ray][below];
    end else if (row_t[r] < m_scene[ray]) begin
      // restart begins on an empty stack
      mk        = K_REST;
      e_node[r] = m_rest[ray];
      e_tmax[r] = m_scene[ray];
      e_wptr[r] = '0;
      e_num[r]  = '0;
    end else begin
      mk = K_SHADER;
    end
    if (mk != row_kind[r]) begin
      note_fail(r, "table result kind differs from the reference model");
    end
  endtask

  task automatic check_row(input int r);
    int k;
    k = row_kind[r];
    if (k == K_NONE) begin
      assert (tarb_valid === 1'b0 && shader_valid === 1'b0) else
        note_fail(r, "an output strobe came after a write-only row");
    end else if (k == K_SHADER) begin
      assert (shader_valid === 1'b1 && tarb_valid === 1'b0) else
        note_fail(r, "expected a shader miss strobe and it did not come");
      if (shader_valid === 1'b1) begin
        compare_field(r, "shader_ray_id", 32'(row_ray[r]), 32'(shader_ray_id));
      end
    end else begin
      assert (tarb_valid === 1'b1 && shader_valid === 1'b0) else
        note_fail(r, "expected an arbiter strobe and it did not come");
      if (tarb_valid === 1'b1) begin
        compare_field(r, "tarb_restart", 32'(k == K_REST), 32'(tarb_restart));
        compare_field(r, "tarb_ray_id", 32'(row_ray[r]), 32'(tarb_ray_id));
        compare_field(r, "tarb_node", 32'(e_node[r]), 32'(tarb_node));
        compare_field(r, "tarb_t_min", row_t[r], tarb_t_min);
        compare_field(r, "tarb_t_max", e_tmax[r], tarb_t_max);
        compare_field(r, "tarb_ss_wptr", 32'(e_wptr[r]), 32'(tarb_ss_wptr));
        compare_field(r, "tarb_ss_num", 32'(e_num[r]), 32'(tarb_ss_num));
      end
    end
    if (row_err[r] == 0) begin
      $display("%s: ok", row_name[r]);
    end else begin
      $display("%s: failed with %0d errors", row_name[r], row_err[r]);
    end
  endtask

  // outputs settle after the rising edge and are sampled on the falling one
  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    if (exp_due.size() != 0 && exp_due[0] == neg_cnt) begin
      check_row(exp_row.pop_front());
      void'(exp_due.pop_front());
    end else begin
      assert (tarb_valid === 1'b0 && shader_valid === 1'b0) else begin
        $display("ERROR: output strobe at cycle %0d with no pop behind it", neg_cnt);
        err_cnt++;
      end
    end
  end

  initial begin
    #((RESET_CYCLES + N_ROWS * 8) * 4);
    $display("ERROR: watchdog expired before all rows were checked");
    $display("RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // table, reset and main loop
  // ----------------------------------------------------------------------
  initial begin
    int n_ok;
    rst              = 1'b1;
    trav_valid       = 1'b0;
    sint_valid       = 1'b0;
    list_valid       = 1'b0;
    trav_op          = op_pop;
    trav_ray_id      = '0;
    trav_ss_wptr     = '0;
    trav_ss_num      = '0;
    trav_push_node   = '0;
    trav_rest_node   = '0;
    trav_t_max       = '0;
    sint_ray_id      = '0;
    sint_t_max_scene = '0;
    list_ray_id      = '0;
    list_ss_wptr     = '0;
    list_ss_num      = '0;
    list_t_max_leaf  = '0;

    add_row("push_r3", P_TRAV, op_push, 3, 1, 1, 16'h0a31, 16'h0, rand_t(), K_NONE, 4);
    add_row("pop_r3", P_TRAV, op_pop, 3, 2, 1, 16'h0, 16'h0, rand_t(), K_TARB, 4);
    add_row("push_r5", P_TRAV, op_push, 5, 3, 0, 16'h0b53, 16'h0, rand_t(), K_NONE, 4);
    add_row("list_pop_r5", P_LIST, op_pop, 5, 0, 1, 16'h0, 16'h0, rand_t(), K_TARB, 4);
    add_row("sint_r7", P_SINT, op_pop, 7, 0, 0, 16'h0, 16'h0, 32'h4120_0000, K_NONE, 4);
    add_row("upd_rest_r7", P_TRAV, op_upd_rest, 7, 0, 0, 16'h0, 16'h0c70, 32'h4140_0000,
            K_NONE, 4);
    add_row("restart_r7", P_TRAV, op_pop, 7, 0, 0, 16'h0, 16'h0, 32'h4000_0000, K_REST, 4);
    add_row("sint_r9", P_SINT, op_pop, 9, 0, 0, 16'h0, 16'h0, 32'h40a0_0000, K_NONE, 4);
    add_row("upd_scene_r9", P_TRAV, op_upd_scene, 9, 0, 0, 16'h0, 16'h0, 32'h4080_0000,
            K_NONE, 4);
    add_row("restart_r9", P_LIST, op_pop, 9, 2, 0, 16'h0, 16'h0, 32'h3f80_0000, K_REST, 4);
    add_row("miss_r9", P_TRAV, op_pop, 9, 1, 0, 16'h0, 16'h0, 32'h4080_0000, K_SHADER, 4);
    add_row("push_rest_r1", P_TRAV, op_push_rest, 1, 0, 0, 16'h0d10, 16'h0d11, rand_t(),
            K_NONE, 4);
    add_row("push_r2", P_TRAV, op_push, 2, 2, 0, 16'h0e22, 16'h0, rand_t(), K_NONE, 4);
    // three pops in flight together
    add_row("b2b_pop_r1", P_TRAV, op_pop, 1, 1, 1, 16'h0, 16'h0, rand_t(), K_TARB, 0);
    add_row("b2b_pop_r2", P_LIST, op_pop, 2, 3, 3, 16'h0, 16'h0, rand_t(), K_TARB, 0);
    add_row("b2b_miss_r1", P_TRAV, op_pop, 1, 0, 0, 16'h0, 16'h0, 32'h7f7f_ffff, K_SHADER, 4);
    // restart fields written along with the push
    add_row("restart_r1", P_TRAV, op_pop, 1, 0, 0, 16'h0, 16'h0, 32'h0000_0000, K_REST, 4);

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < N_ROWS; r++) begin
      @(posedge clk);
      drive_row(r);
      model_row(r);
      exp_row.push_back(r);
      exp_due.push_back(neg_cnt + 4);
      repeat (row_gap[r]) begin
        @(posedge clk);
        idle_ports();
      end
    end
    while (exp_row.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);

    n_ok = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      if (row_err[r] == 0) begin
        n_ok++;
      end
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", N_ROWS, n_ok, N_ROWS - n_ok,
             err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
design/ss_pkg.sv
design/ss_links.sv
design/ss_req_decode.sv
design/ss_store.sv
design/ss_resolve.sv
design/shortstack_unit.sv
tests/shortstack_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= shortstack_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
